//--- logic/pad_ctrl_pkg.sv
package pad_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Pad frame layout
   ////////////////////////////////////////////////////////////

   localparam int unsigned N_PADS = 17;

   // SPI master pads
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;
   // UART pads
   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;
   // SDIO pads
   localparam int unsigned PAD_SDIO_CLK   = 9;
   localparam int unsigned PAD_SDIO_CMD   = 10;
   localparam int unsigned PAD_SDIO_DATA0 = 11;
   localparam int unsigned PAD_SDIO_DATA1 = 12;
   localparam int unsigned PAD_SDIO_DATA2 = 13;
   localparam int unsigned PAD_SDIO_DATA3 = 14;
   // I2C0 pads
   localparam int unsigned PAD_I2C0_SDA   = 15;
   localparam int unsigned PAD_I2C0_SCL   = 16;

   // Pads able to carry the second I2C bus, highest priority first
   localparam int unsigned N_I2C1_PADS = 3;
   localparam int unsigned I2C1_SDA_PADS [N_I2C1_PADS] = '{
      PAD_SPIM_SDIO2, PAD_UART_RX, PAD_SDIO_DATA2
   };
   localparam int unsigned I2C1_SCL_PADS [N_I2C1_PADS] = '{
      PAD_SPIM_SDIO3, PAD_UART_TX, PAD_SDIO_DATA3
   };

   ////////////////////////////////////////////////////////////
   // Widths and select codes
   ////////////////////////////////////////////////////////////

   typedef logic [1:0]        pad_sel_t;
   typedef logic [5:0]        pad_cfg_t;   // drive strength and pulls
   typedef logic [N_PADS-1:0] pad_vec_t;

   localparam pad_sel_t SEL_PERIPH = 2'd0;
   localparam pad_sel_t SEL_GPIO   = 2'd1;
   localparam pad_sel_t SEL_I2C1   = 2'd2;
   localparam pad_sel_t SEL_IDLE   = 2'd3;

   ////////////////////////////////////////////////////////////
   // Peripheral bundles
   ////////////////////////////////////////////////////////////

   // One pad driver
   typedef struct packed {
      logic out;
      logic oe;
   } pad_drive_t;

   typedef struct packed {
      logic       sck;
      logic [1:0] csn;
      logic [3:0] sdo;
      logic [3:0] oen;   // active low
   } spim_out_t;

   typedef struct packed {
      logic       clk;
      logic       cmd;
      logic       cmd_oen;
      logic [3:0] data;
      logic [3:0] data_oen;
   } sdio_out_t;

   typedef struct packed {
      logic scl_out;
      logic scl_oe;
      logic sda_out;
      logic sda_oe;
   } i2c_out_t;

   typedef struct packed {
      logic scl;
      logic sda;
   } i2c_in_t;

   typedef struct packed {
      logic       cmd;
      logic [3:0] data;
   } sdio_in_t;

endpackage

//--- logic/periph_pad_map.sv
`timescale 1ns/1ps

module periph_pad_map import pad_ctrl_pkg::*; (
   input  spim_out_t                 spim_i,
   input  sdio_out_t                 sdio_i,
   input  logic                      uart_tx_i,
   input  i2c_out_t                  i2c0_i,
   input  i2c_out_t                  i2c1_i,
   output pad_drive_t [N_PADS-1:0]   periph_o,
   output pad_drive_t [N_PADS-1:0]   i2c1_alt_o
);

   ////////////////////////////////////////////////////////////
   // Function 0 drivers
   ////////////////////////////////////////////////////////////

   always_comb begin
      // SPI data lines take their enable from the inverted oen
      for (int i = 0; i < 4; i++) begin
         periph_o[PAD_SPIM_SDIO0 + i] = '{out: spim_i.sdo[i], oe: ~spim_i.oen[i]};
      end

      // Chip selects and clock always driven
      periph_o[PAD_SPIM_CSN0] = '{out: spim_i.csn[0], oe: 1'b1};
      periph_o[PAD_SPIM_CSN1] = '{out: spim_i.csn[1], oe: 1'b1};
      periph_o[PAD_SPIM_SCK]  = '{out: spim_i.sck, oe: 1'b1};

      // UART rx pad is input only
      periph_o[PAD_UART_RX] = '{out: 1'b0, oe: 1'b0};
      periph_o[PAD_UART_TX] = '{out: uart_tx_i, oe: 1'b1};

      // SDIO clock out of the host
      periph_o[PAD_SDIO_CLK] = '{out: sdio_i.clk, oe: 1'b1};
      // Bidirectional cmd line
      periph_o[PAD_SDIO_CMD] = '{out: sdio_i.cmd, oe: ~sdio_i.cmd_oen};
      for (int i = 0; i < 4; i++) begin
         periph_o[PAD_SDIO_DATA0 + i] = '{out: sdio_i.data[i], oe: ~sdio_i.data_oen[i]};
      end

      // I2C0 enables are already active high
      periph_o[PAD_I2C0_SDA] = '{out: i2c0_i.sda_out, oe: i2c0_i.sda_oe};
      periph_o[PAD_I2C0_SCL] = '{out: i2c0_i.scl_out, oe: i2c0_i.scl_oe};
   end

   ////////////////////////////////////////////////////////////
   // Function 2 drivers
   ////////////////////////////////////////////////////////////

   always_comb begin
      // Pads without an I2C1 option stay quiet
      i2c1_alt_o = '0;

      // Same bus copied to every capable pad
      for (int k = 0; k < N_I2C1_PADS; k++) begin
         i2c1_alt_o[I2C1_SDA_PADS[k]] = '{out: i2c1_i.sda_out, oe: i2c1_i.sda_oe};
         i2c1_alt_o[I2C1_SCL_PADS[k]] = '{out: i2c1_i.scl_out, oe: i2c1_i.scl_oe};
      end
   end

endmodule

//--- logic/pad_out_mux.sv
`timescale 1ns/1ps

module pad_out_mux import pad_ctrl_pkg::*; #(
   parameter int unsigned N_PADS = 17
) (
   input  pad_sel_t   [N_PADS-1:0] pad_sel_i,
   input  pad_drive_t [N_PADS-1:0] periph_i,
   input  pad_drive_t [N_PADS-1:0] i2c1_alt_i,
   input  logic       [N_PADS-1:0] gpio_out_i,
   input  logic       [N_PADS-1:0] gpio_dir_i,
   input  pad_cfg_t   [N_PADS-1:0] gpio_cfg_i,
   input  pad_cfg_t   [N_PADS-1:0] pad_cfg_i,
   output pad_drive_t [N_PADS-1:0] pad_o,
   output pad_cfg_t   [N_PADS-1:0] pad_cfg_o
);

   ////////////////////////////////////////////////////////////
   // Output and enable select
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         case (pad_sel_i[p])
            // Owning peripheral
            SEL_PERIPH: pad_o[p] = periph_i[p];
            // GPIO direction doubles as output enable
            SEL_GPIO:   pad_o[p] = '{out: gpio_out_i[p], oe: gpio_dir_i[p]};
            // Second I2C bus or zero on pads without it
            SEL_I2C1:   pad_o[p] = i2c1_alt_i[p];
            // Idle pad
            default:    pad_o[p] = '{out: 1'b0, oe: 1'b0};
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Pad configuration
   ////////////////////////////////////////////////////////////

   // GPIO owns the pad settings only when it owns the pad
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         if (pad_sel_i[p] == SEL_GPIO) begin
            pad_cfg_o[p] = gpio_cfg_i[p];
         end else begin
            pad_cfg_o[p] = pad_cfg_i[p];
         end
      end
   end

endmodule

//--- logic/pad_in_route.sv
`timescale 1ns/1ps

module pad_in_route import pad_ctrl_pkg::*; (
   input  pad_sel_t [N_PADS-1:0] pad_sel_i,
   input  pad_vec_t              pad_in_i,
   output logic     [3:0]        spim_sdi_o,
   output sdio_in_t              sdio_o,
   output logic                  uart_rx_o,
   output i2c_in_t               i2c0_o,
   output i2c_in_t               i2c1_o,
   output pad_vec_t              gpio_in_o
);

   // Pad value when the pad runs the given function, idle level otherwise
   function automatic logic gate_in(
      pad_sel_t sel,
      pad_sel_t code,
      logic     pad,
      logic     idle
   );
      return (sel == code) ? pad : idle;
   endfunction

   ////////////////////////////////////////////////////////////
   // Peripheral inputs
   ////////////////////////////////////////////////////////////

   always_comb begin
      // SPI and SDIO idle low
      for (int i = 0; i < 4; i++) begin
         spim_sdi_o[i] = gate_in(pad_sel_i[PAD_SPIM_SDIO0 + i], SEL_PERIPH,
                                 pad_in_i[PAD_SPIM_SDIO0 + i], 1'b0);
         sdio_o.data[i] = gate_in(pad_sel_i[PAD_SDIO_DATA0 + i], SEL_PERIPH,
                                  pad_in_i[PAD_SDIO_DATA0 + i], 1'b0);
      end
      sdio_o.cmd = gate_in(pad_sel_i[PAD_SDIO_CMD], SEL_PERIPH, pad_in_i[PAD_SDIO_CMD], 1'b0);

      // UART line idles at mark
      uart_rx_o = gate_in(pad_sel_i[PAD_UART_RX], SEL_PERIPH, pad_in_i[PAD_UART_RX], 1'b1);

      // Released I2C bus reads high
      i2c0_o.sda = gate_in(pad_sel_i[PAD_I2C0_SDA], SEL_PERIPH, pad_in_i[PAD_I2C0_SDA], 1'b1);
      i2c0_o.scl = gate_in(pad_sel_i[PAD_I2C0_SCL], SEL_PERIPH, pad_in_i[PAD_I2C0_SCL], 1'b1);
   end

   ////////////////////////////////////////////////////////////
   // GPIO inputs
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         gpio_in_o[p] = gate_in(pad_sel_i[p], SEL_GPIO, pad_in_i[p], 1'b0);
      end
   end

   ////////////////////////////////////////////////////////////
   // Second I2C bus
   ////////////////////////////////////////////////////////////

   // Walk from lowest priority up so the SPI pads win last
   always_comb begin
      i2c1_o = '{scl: 1'b1, sda: 1'b1};
      for (int k = N_I2C1_PADS - 1; k >= 0; k--) begin
         if (pad_sel_i[I2C1_SDA_PADS[k]] == SEL_I2C1) begin
            i2c1_o.sda = pad_in_i[I2C1_SDA_PADS[k]];
         end
         if (pad_sel_i[I2C1_SCL_PADS[k]] == SEL_I2C1) begin
            i2c1_o.scl = pad_in_i[I2C1_SCL_PADS[k]];
         end
      end
   end

endmodule

//--- logic/pad_ctrl_top.sv
`timescale 1ns/1ps

module pad_ctrl_top import pad_ctrl_pkg::*; #(
   parameter int unsigned PAD_COUNT = 17
) (
   // Peripheral outputs
   input  spim_out_t                 spim_i,
   input  sdio_out_t                 sdio_i,
   input  logic                      uart_tx_i,
   input  i2c_out_t                  i2c0_i,
   input  i2c_out_t                  i2c1_i,
   // GPIO controller
   input  pad_vec_t                  gpio_out_i,
   input  pad_vec_t                  gpio_dir_i,
   input  pad_cfg_t   [PAD_COUNT-1:0] gpio_cfg_i,
   // Mux control and default settings
   input  pad_cfg_t   [PAD_COUNT-1:0] pad_cfg_i,
   input  pad_sel_t   [PAD_COUNT-1:0] pad_sel_i,
   // Raw pad inputs
   input  pad_vec_t                  pad_in_i,
   // Peripheral inputs
   output logic       [3:0]          spim_sdi_o,
   output sdio_in_t                  sdio_o,
   output logic                      uart_rx_o,
   output i2c_in_t                   i2c0_o,
   output i2c_in_t                   i2c1_o,
   output pad_vec_t                  gpio_in_o,
   // Pad frame drivers
   output pad_drive_t [PAD_COUNT-1:0] pad_o,
   output pad_cfg_t   [PAD_COUNT-1:0] pad_cfg_o
);

   // Pad map in the package is fixed at 17 pads
   if (PAD_COUNT != N_PADS) begin : gen_pad_count_check
      $error("pad_ctrl_top PAD_COUNT %0d differs from pad map size %0d", PAD_COUNT, N_PADS);
   end

   ////////////////////////////////////////////////////////////
   // Output path
   ////////////////////////////////////////////////////////////

   // Function 0 and function 2 sources per pad
   pad_drive_t [PAD_COUNT-1:0] periph_drive;
   pad_drive_t [PAD_COUNT-1:0] i2c1_drive;

   periph_pad_map periph_pad_map_i (
      .spim_i     (spim_i),
      .sdio_i     (sdio_i),
      .uart_tx_i  (uart_tx_i),
      .i2c0_i     (i2c0_i),
      .i2c1_i     (i2c1_i),
      .periph_o   (periph_drive),
      .i2c1_alt_o (i2c1_drive)
   );

   pad_out_mux #(
      .N_PADS (PAD_COUNT)
   ) pad_out_mux_i (
      .pad_sel_i  (pad_sel_i),
      .periph_i   (periph_drive),
      .i2c1_alt_i (i2c1_drive),
      .gpio_out_i (gpio_out_i),
      .gpio_dir_i (gpio_dir_i),
      .gpio_cfg_i (gpio_cfg_i),
      .pad_cfg_i  (pad_cfg_i),
      .pad_o      (pad_o),
      .pad_cfg_o  (pad_cfg_o)
   );

   ////////////////////////////////////////////////////////////
   // Input path
   ////////////////////////////////////////////////////////////

   pad_in_route pad_in_route_i (
      .pad_sel_i  (pad_sel_i),
      .pad_in_i   (pad_in_i),
      .spim_sdi_o (spim_sdi_o),
      .sdio_o     (sdio_o),
      .uart_rx_o  (uart_rx_o),
      .i2c0_o     (i2c0_o),
      .i2c1_o     (i2c1_o),
      .gpio_in_o  (gpio_in_o)
   );

endmodule

//--- dv/pad_ctrl_tb.sv
`timescale 1ns/1ps

module pad_ctrl_tb import pad_ctrl_pkg::*; ();

   localparam string CASES_FILE   = "dv/pad_ctrl_cases.txt";
   localparam int    CLK_PERIOD   = 40;
   localparam int    RESET_CYCLES = 16;
   localparam int    DRIVE_DELAY  = 5;

   logic clk;

   // DUT inputs
   spim_out_t               spim;
   sdio_out_t               sdio;
   logic                    uart_tx;
   i2c_out_t                i2c0_out;
   i2c_out_t                i2c1_out;
   pad_vec_t                gpio_out;
   pad_vec_t                gpio_dir;
   pad_vec_t                pad_in;
   pad_cfg_t   [N_PADS-1:0] gpio_cfg;
   pad_cfg_t   [N_PADS-1:0] dflt_cfg;
   pad_sel_t   [N_PADS-1:0] pad_sel;

   // DUT outputs
   logic       [3:0]        spim_sdi;
   sdio_in_t                sdio_in;
   logic                    uart_rx;
   i2c_in_t                 i2c0_in;
   i2c_in_t                 i2c1_in;
   pad_vec_t                gpio_in;
   pad_drive_t [N_PADS-1:0] pad_drv;
   pad_cfg_t   [N_PADS-1:0] pad_cfg;

   // Name and expected values of the current case
   logic [8*16-1:0] case_name;
   pad_cfg_t        gcfg_base;
   pad_cfg_t        dcfg_base;
   pad_vec_t        exp_out;
   pad_vec_t        exp_oe;
   pad_vec_t        exp_cfg_mask;
   pad_vec_t        exp_gpio_in;
   logic [3:0]      exp_sdi;
   sdio_in_t        exp_sdio;
   logic            exp_rx;
   i2c_in_t         exp_i2c0;
   i2c_in_t         exp_i2c1;

   string case_lines[$];
   int    n_cases = 0;

   pad_ctrl_top #(
      .PAD_COUNT (N_PADS)
   ) pad_ctrl_top_i (
      .spim_i     (spim),
      .sdio_i     (sdio),
      .uart_tx_i  (uart_tx),
      .i2c0_i     (i2c0_out),
      .i2c1_i     (i2c1_out),
      .gpio_out_i (gpio_out),
      .gpio_dir_i (gpio_dir),
      .gpio_cfg_i (gpio_cfg),
      .pad_cfg_i  (dflt_cfg),
      .pad_sel_i  (pad_sel),
      .pad_in_i   (pad_in),
      .spim_sdi_o (spim_sdi),
      .sdio_o     (sdio_in),
      .uart_rx_o  (uart_rx),
      .i2c0_o     (i2c0_in),
      .i2c1_o     (i2c1_in),
      .gpio_in_o  (gpio_in),
      .pad_o      (pad_drv),
      .pad_cfg_o  (pad_cfg)
   );

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %0s, %0s: expected %h, actual %h",
                  case_name, what, expected, actual);
         $display("Simulation failed");
         $fatal(1, "value check failed");
      end
   endtask

   // Keeps test lines and drops comments and blank lines
   task automatic load_cases();
      int    fd;
      string line;
      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the cases file %0s", CASES_FILE);
         $display("Simulation failed");
         $fatal(1, "cases file missing");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            case_lines.push_back(line);
         end
      end
      $fclose(fd);
   endtask

   task automatic apply_case(input string line);
      int n;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  case_name, pad_sel, spim, sdio, uart_tx, i2c0_out, i2c1_out,
                  gpio_out, gpio_dir, gcfg_base, dcfg_base, pad_in,
                  exp_out, exp_oe, exp_cfg_mask, exp_sdi, exp_sdio, exp_rx,
                  exp_i2c0, exp_i2c1, exp_gpio_in);
      if (n != 21) begin
         $display("A line of the cases file has %0d fields instead of 21", n);
         $display("Simulation failed");
         $fatal(1, "bad cases line");
      end
      // Each pad cfg is the base mixed with the pad index
      for (int p = 0; p < N_PADS; p++) begin
         gpio_cfg[p] = gcfg_base ^ pad_cfg_t'(p);
         dflt_cfg[p] = dcfg_base ^ pad_cfg_t'(p);
      end
   endtask

   task automatic check_case();
      pad_cfg_t cfg_exp;
      for (int p = 0; p < N_PADS; p++) begin
         cfg_exp = exp_cfg_mask[p] ? gpio_cfg[p] : dflt_cfg[p];
         check_value($sformatf("pad %0d out", p), 32'(exp_out[p]), 32'(pad_drv[p].out));
         check_value($sformatf("pad %0d oe", p), 32'(exp_oe[p]), 32'(pad_drv[p].oe));
         check_value($sformatf("pad %0d cfg", p), 32'(cfg_exp), 32'(pad_cfg[p]));
      end
      check_value("spim sdi", 32'(exp_sdi), 32'(spim_sdi));
      check_value("sdio in", 32'(exp_sdio), 32'(sdio_in));
      check_value("uart rx", 32'(exp_rx), 32'(uart_rx));
      check_value("i2c0 in", 32'(exp_i2c0), 32'(i2c0_in));
      check_value("i2c1 in", 32'(exp_i2c1), 32'(i2c1_in));
      check_value("gpio in", 32'(exp_gpio_in), 32'(gpio_in));
   endtask

   ////////////////////////////////////////////////////////////
   // Clock, stimulus and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      // All pads idle until the first case
      spim     = '0;
      sdio     = '0;
      uart_tx  = 1'b0;
      i2c0_out = '0;
      i2c1_out = '0;
      gpio_out = '0;
      gpio_dir = '0;
      gpio_cfg = '0;
      dflt_cfg = '0;
      pad_sel  = {N_PADS{SEL_IDLE}};
      pad_in   = '0;
      load_cases();
      if (case_lines.size() == 0) begin
         $display("The cases file holds no test lines");
         $display("Simulation failed");
         $fatal(1, "no cases");
      end
      n_cases = case_lines.size();
      // Idle start in place of a reset
      repeat (RESET_CYCLES) @(posedge clk);
      foreach (case_lines[i]) begin
         @(posedge clk);
         #DRIVE_DELAY;
         apply_case(case_lines[i]);
         // Sample just ahead of the next edge
         #(CLK_PERIOD - DRIVE_DELAY - 1);
         check_case();
      end
      $display("Simulation passed");
      $finish;
   end

   initial begin
      wait (n_cases > 0);
      #((n_cases + 20) * CLK_PERIOD * 2);
      $display("Watchdog expired before all cases were checked");
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

endmodule

//--- dv/pad_ctrl_cases.txt
# name sel spim sdio tx i2c0 i2c1 gpio_out gpio_dir gcfg dcfg pad_in
#   then expected: out oe cfg_mask spim_sdi sdio_in uart_rx i2c0_in i2c1_in gpio_in
per_all_a 000000000 653 2CA 1 9 F 1FFFF 1FFFF 2A 15 1A5C3 16565 0AF7C 00000 3 14 1 3 3 00000
per_all_b 000000000 1AC 535 0 6 0 00000 00000 2A 15 05A3C 09A1A 15373 00000 C 0B 0 0 3 00000
gpio_all_a 155555555 7FF 7FF 1 F F 1B2D4 0C3F1 2A 15 13579 1B2D4 0C3F1 1FFFF 0 00 1 3 3 13579
gpio_all_b 155555555 000 000 0 0 0 04D2B 13C0E 07 38 0ECA8 04D2B 13C0E 1FFFF 0 00 1 3 3 0ECA8
idle_all 3FFFFFFFF 7FF 7FF 1 F F 1FFFF 1FFFF 2A 15 1FFFF 00000 00000 00000 0 00 1 3 3 00000
idle_cfg 3FFFFFFFF 000 000 0 0 0 00000 00000 11 2E 1FFFF 00000 00000 00000 0 00 1 3 3 00000
i2c1_all 2AAAAAAAA 7FF 7FF 1 F D 1FFFF 1FFFF 2A 15 1FFFB 04108 0618C 00000 0 00 1 3 2 00000
i2c1_uart 3EBFEBFFF 7FF 7FF 1 F 6 1FFFF 1FFFF 2A 15 04080 02080 04100 00000 0 00 1 3 1 00000
i2c1_sdio 3EBFFFFFF 7FF 7FF 1 F F 1FFFF 1FFFF 2A 15 02000 06000 06000 00000 0 00 1 3 1 00000
i2c1_none 2BEABEAFA 7FF 7FF 1 F F 1FFFF 1FFFF 2A 15 1FFFF 00000 00000 00000 0 00 1 3 3 00000
prio_spi 3EBFEBFAF 7FF 7FF 1 F 0 1FFFF 1FFFF 2A 15 04104 00000 00000 00000 0 00 1 3 1 00000
prio_mix 3FBFC3FBF 7FF 7FF 1 F A 1FFFF 1FFFF 2A 15 00008 02108 00100 00000 0 00 0 3 2 00000
mix_a 2BFFD4000 653 7FF 1 F F 00180 00080 2A 15 1A5C3 001E5 000FC 00180 3 00 1 3 3 00180
mix_b 040003F55 7FF 2CA 0 9 F 0800A 0000C 2A 15 05A3C 1E40A 02F0C 0800F 0 0B 0 1 3 0000C
mix_c 0E4E4E4E4 1AC 535 0 6 D 1FFFF 00000 2A 15 0F0F0 07232 15115 02222 0 02 1 1 2 02020
mix_d 015568000 70F 7FF 1 F 5 05400 07E00 2A 15 1C8A5 1D470 1FFF0 07E00 5 00 1 3 1 04800

//--- pad_ctrl.f
logic/pad_ctrl_pkg.sv
logic/periph_pad_map.sv
logic/pad_out_mux.sv
logic/pad_in_route.sv
logic/pad_ctrl_top.sv
dv/pad_ctrl_tb.sv

//--- Makefile
TOP := pad_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f pad_ctrl.f --top-module $(TOP) -Mdir build
	out=$$(./build/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf build
